// File: if_stage.f
+incdir+include
src/if_pkg.sv
src/if_pc_select.sv
src/if_fetch_unit.sv
src/if_id_register.sv
src/if_pc_check.sv
src/if_stage.sv
dv/tb_if_stage.sv

// File: Bender.yml
package:
  name: if_stage

export_include_dirs:
  - include

sources:
  - src/if_pkg.sv
  - src/if_pc_select.sv
  - src/if_fetch_unit.sv
  - src/if_id_register.sv
  - src/if_pc_check.sv
  - src/if_stage.sv
  - target: test
    files:
      - dv/tb_if_stage.sv

// File: dv/tb_if_stage.sv
////////////////////////////////////////
// testbench for the fetch stage top level
// memory responder, directed tests, watchdog
////////////////////////////////////////

`timescale 1ns/1ps

`include "if_config.svh"

module tb_if_stage;

  localparam logic [`IF_XLEN-1:0] DATA_KEY = 32'hA5A5_A5A5;
  localparam logic [`IF_XLEN-1:0] ERR_LO   = 32'h0000_C008;
  localparam logic [`IF_XLEN-1:0] ERR_HI   = 32'h0000_C00C;
  localparam int WORD_TIMEOUT = 40;
  // per-test budgets in clock cycles
  localparam int RESET_CYCLES    = 10;
  localparam int BOOT_CYCLES     = 120;
  localparam int REDIRECT_CYCLES = 150;
  localparam int EXC_CYCLES      = 160;
  localparam int STALL_CYCLES    = 100;
  localparam int BUSERR_CYCLES   = 80;
  localparam int WATCHDOG_NS = (RESET_CYCLES + BOOT_CYCLES + REDIRECT_CYCLES + EXC_CYCLES
                                + STALL_CYCLES + BUSERR_CYCLES) * 2 * 10;

  logic clk_i, rst_ni, req_i, pc_set_i;
  if_pkg::pc_sel_e     pc_mux_i;
  if_pkg::exc_pc_sel_e exc_pc_mux_i;
  logic [5:0]          exc_cause_i;
  logic [`IF_XLEN-1:0] boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i;
  logic [`IF_XLEN-1:0] csr_mtvec_i, csr_mtvecx_i, instr_addr_o, instr_rdata_i;
  logic [`IF_XLEN-1:0] instr_rdata_id_o, pc_id_o, pc_if_o;
  logic csr_mtvec_init_o, instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic id_in_ready_i, instr_valid_clear_i, instr_valid_id_o, instr_new_id_o;
  logic instr_fetch_err_o, if_busy_o, pc_mismatch_alert_o;

  int errors, checks, grant_count, init_pulses;
  logic [`IF_XLEN-1:0] gnt_addrs [$];
  logic [15:0] lfsr_q = 16'd20;
  if_pkg::fetch_state_e fsm_state;

  // fetch FSM state for debug prints
  assign fsm_state = uut.u_fetch_unit.state_q;

  if_stage uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // reference rules and helpers
  ////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = (val << 1) | lfsr_q[0];
    end
  endtask

  function automatic logic in_err_window(input logic [`IF_XLEN-1:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  // trap vector from the base with its low byte cleared
  // irq entries add the id times four
  function automatic logic [`IF_XLEN-1:0] vector_rule(input if_pkg::exc_pc_sel_e sel,
                                                      input logic [5:0] cause);
    logic [`IF_XLEN-1:0] offs;
    offs = 32'(cause[4:0]) * 4;
    case (sel)
      if_pkg::EXC_PC_IRQ:     return (csr_mtvec_i & ~32'hFF) + offs;
      if_pkg::EXC_PC_IRQ_X:   return (csr_mtvecx_i & ~32'hFF) + offs;
      if_pkg::EXC_PC_DBD:     return `IF_DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: return `IF_DM_EXC_ADDR;
      default:                return csr_mtvec_i & ~32'hFF;
    endcase
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [`IF_XLEN-1:0] exp, input logic [`IF_XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s: expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic report_test(input string test, input int err0);
    $display("%s finished with %0d errors", test, errors - err0);
  endtask

  ////////////////////////////////////////
  // memory responder and monitors
  ////////////////////////////////////////

  // grant after 0..3 cycles and rvalid 1..3 cycles after the grant
  initial begin : responder
    logic [`IF_XLEN-1:0] addr;
    int dly;
    forever begin
      @(posedge clk_i);
      #1;
      instr_rvalid_i = 1'b0;
      if (rst_ni && instr_req_o) begin
        draw_bits(2, dly);
        repeat (dly) begin
          @(posedge clk_i);
          #1;
        end
        addr = instr_addr_o;
        instr_gnt_i = 1'b1;
        grant_count++;
        gnt_addrs.push_back(addr);
        @(posedge clk_i);
        #1;
        instr_gnt_i = 1'b0;
        draw_bits(2, dly);
        repeat (dly % 3) begin
          @(posedge clk_i);
          #1;
        end
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = addr ^ DATA_KEY;
        instr_err_i    = in_err_window(addr);
      end
    end
  end

  always @(negedge clk_i) begin
    if (csr_mtvec_init_o) begin
      init_pulses++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, fetch FSM in %s", WATCHDOG_NS, fsm_state.name());
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  // waits for the next word in ID and checks it against the memory rules
  task automatic take_word(input string test, input logic [`IF_XLEN-1:0] exp_pc);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #2;
      cycles++;
    end while (!instr_new_id_o && cycles < WORD_TIMEOUT);
    if (!instr_new_id_o) begin
      errors++;
      $display("%s: no instruction reached ID within %0d cycles, fetch FSM in %s",
               test, WORD_TIMEOUT, fsm_state.name());
    end else begin
      check_value(test, "pc_id", exp_pc, pc_id_o);
      check_value(test, "rdata", exp_pc ^ DATA_KEY, instr_rdata_id_o);
      check_value(test, "fetch_err", 32'(in_err_window(exp_pc)), 32'(instr_fetch_err_o));
      check_value(test, "valid_id", 32'd1, 32'(instr_valid_id_o));
      // IF PC already names the following word
      check_value(test, "pc_if", exp_pc + `IF_INSTR_BYTES, pc_if_o);
      check_value(test, "pc_alert", 32'd0, 32'(pc_mismatch_alert_o));
    end
  endtask

  // called 1 ns after an edge and returns 1 ns after the next one
  task automatic pulse_pc_set(input if_pkg::pc_sel_e sel, input if_pkg::exc_pc_sel_e exc_sel,
                              input logic [5:0] cause);
    pc_set_i     = 1'b1;
    pc_mux_i     = sel;
    exc_pc_mux_i = exc_sel;
    exc_cause_i  = cause;
    @(posedge clk_i);
    #1;
    pc_set_i = 1'b0;
  endtask

  // redirect while a request is likely in flight and follow two words
  task automatic follow_redirect(input string test, input if_pkg::pc_sel_e sel,
                                 input if_pkg::exc_pc_sel_e exc_sel, input logic [5:0] cause,
                                 input logic [`IF_XLEN-1:0] target);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      #1;
      n++;
    end while (!if_busy_o && n < 20);
    pulse_pc_set(sel, exc_sel, cause);
    take_word(test, target);
    take_word(test, target + `IF_INSTR_BYTES);
  endtask

  task automatic test_boot_seq;
    logic [`IF_XLEN-1:0] base;
    int err0;
    int i;
    err0 = errors;
    // outputs that must be low out of reset
    check_value("boot_seq", "req", 32'd0, 32'(instr_req_o));
    check_value("boot_seq", "valid_id", 32'd0, 32'(instr_valid_id_o));
    check_value("boot_seq", "new_id", 32'd0, 32'(instr_new_id_o));
    check_value("boot_seq", "busy", 32'd0, 32'(if_busy_o));
    check_value("boot_seq", "pc_alert", 32'd0, 32'(pc_mismatch_alert_o));
    check_value("boot_seq", "mtvec_init", 32'd0, 32'(csr_mtvec_init_o));
    base = (boot_addr_i & ~32'hFF) | 32'h80;
    gnt_addrs.delete();
    init_pulses = 0;
    @(posedge clk_i);
    #1;
    req_i = 1'b1;
    pulse_pc_set(if_pkg::PC_BOOT, if_pkg::EXC_PC_EXC, 6'd0);
    for (i = 0; i < 8; i++) begin
      take_word("boot_seq", base + 4 * i);
    end
    check_value("boot_seq", "mtvec_init pulses", 32'd1, 32'(init_pulses));
    check_value("boot_seq", "enough grants", 32'd1, 32'(gnt_addrs.size() >= 8));
    for (i = 0; i < 8 && i < gnt_addrs.size(); i++) begin
      check_value("boot_seq", "bus addr", base + 4 * i, gnt_addrs[i]);
    end
    report_test("boot_seq", err0);
  endtask

  task automatic test_redirects;
    int err0;
    err0 = errors;
    @(posedge clk_i);
    #1;
    branch_target_i = 32'h0000_4000;
    csr_mepc_i      = 32'h0000_5010;
    csr_depc_i      = 32'h0000_6020;
    follow_redirect("redirect_jump", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 6'd0, 32'h0000_4000);
    follow_redirect("redirect_eret", if_pkg::PC_ERET, if_pkg::EXC_PC_EXC, 6'd0, 32'h0000_5010);
    follow_redirect("redirect_dret", if_pkg::PC_DRET, if_pkg::EXC_PC_EXC, 6'd0, 32'h0000_6020);
    // stall ID and clear valid so nothing can refill it
    @(posedge clk_i);
    #1;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    instr_valid_clear_i = 1'b0;
    #1;
    check_value("redirects", "valid after clear", 32'd0, 32'(instr_valid_id_o));
    @(posedge clk_i);
    #1;
    id_in_ready_i = 1'b1;
    report_test("redirects", err0);
  endtask

  task automatic test_exc_vectors;
    if_pkg::exc_pc_sel_e sel;
    logic [5:0] cause;
    int err0;
    int i;
    err0 = errors;
    @(posedge clk_i);
    #1;
    csr_mtvec_i  = 32'h0000_8001;
    csr_mtvecx_i = 32'h0000_9A03;
    for (i = 0; i < 5; i++) begin
      sel   = if_pkg::exc_pc_sel_e'(i);
      // bit 5 marks interrupts
      // ids 7 and 17 go to the two irq bases
      cause = (i == 1) ? 6'h27 : (i == 2) ? 6'h31 : 6'h02;
      follow_redirect({"exc_", sel.name()}, if_pkg::PC_EXC, sel, cause, vector_rule(sel, cause));
    end
    report_test("exc_vectors", err0);
  endtask

  task automatic test_back_pressure;
    logic [`IF_XLEN-1:0] held_pc;
    int err0;
    int i;
    err0 = errors;
    // second word after the jump sits in ID through the stall
    held_pc = 32'h0000_7000 + `IF_INSTR_BYTES;
    @(posedge clk_i);
    #1;
    branch_target_i = 32'h0000_7000;
    follow_redirect("back_pressure", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 6'd0, 32'h0000_7000);
    @(posedge clk_i);
    #1;
    id_in_ready_i = 1'b0;
    @(posedge clk_i);
    #2;
    grant_count = 0;
    repeat (20) begin
      @(posedge clk_i);
      #2;
      check_value("back_pressure", "held pc_id", held_pc, pc_id_o);
      check_value("back_pressure", "held rdata", held_pc ^ DATA_KEY, instr_rdata_id_o);
      check_value("back_pressure", "new_id", 32'd0, 32'(instr_new_id_o));
    end
    check_value("back_pressure", "more than one grant", 32'd0, 32'(grant_count > 1));
    // stream picks up right after the held word
    @(posedge clk_i);
    #1;
    id_in_ready_i = 1'b1;
    for (i = 1; i <= 4; i++) begin
      take_word("back_pressure", held_pc + 4 * i);
    end
    report_test("back_pressure", err0);
  endtask

  task automatic test_bus_error;
    int err0;
    int i;
    err0 = errors;
    @(posedge clk_i);
    #1;
    branch_target_i = 32'h0000_C000;
    follow_redirect("bus_error", if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 6'd0, 32'h0000_C000);
    // error window sits at C008 with a neighbour on each side
    for (i = 2; i < 5; i++) begin
      take_word("bus_error", 32'h0000_C000 + 4 * i);
    end
    report_test("bus_error", err0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin : main
    errors = 0;
    checks = 0;
    grant_count = 0;
    init_pulses = 0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = if_pkg::PC_BOOT;
    exc_pc_mux_i = if_pkg::EXC_PC_EXC;
    exc_cause_i = 6'd0;
    boot_addr_i = 32'h0000_1234;
    branch_target_i = '0;
    csr_mepc_i = '0;
    csr_depc_i = '0;
    csr_mtvec_i = '0;
    csr_mtvecx_i = '0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_boot_seq();
    test_redirects();
    test_exc_vectors();
    test_back_pressure();
    test_bus_error();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: src/if_stage.sv
////////////////////////////////////////
// instruction fetch stage top level
// PC select, fetch unit, IF-ID register and
// PC check wired to the core and the bus
////////////////////////////////////////

`timescale 1ns/1ps

`include "if_config.svh"

module if_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  // fetch enable and boot base
  input  logic                req_i,
  input  logic [`IF_XLEN-1:0] boot_addr_i,
  // redirect from the controller
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic [5:0]          exc_cause_i,
  input  logic [`IF_XLEN-1:0] branch_target_i,
  // csr values
  input  logic [`IF_XLEN-1:0] csr_mepc_i,
  input  logic [`IF_XLEN-1:0] csr_depc_i,
  input  logic [`IF_XLEN-1:0] csr_mtvec_i,
  input  logic [`IF_XLEN-1:0] csr_mtvecx_i,
  output logic                csr_mtvec_init_o,
  // instruction bus, request and grant
  output logic                instr_req_o,
  output logic [`IF_XLEN-1:0] instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [`IF_XLEN-1:0] instr_rdata_i,
  input  logic                instr_err_i,
  // ID stage side
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [`IF_XLEN-1:0] instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output logic [`IF_XLEN-1:0] pc_id_o,
  output logic [`IF_XLEN-1:0] pc_if_o,
  // status
  output logic                if_busy_o,
  output logic                pc_mismatch_alert_o
);

  logic [`IF_XLEN-1:0] fetch_addr_n;
  logic                fetch_valid;
  logic                fetch_ready;
  logic [`IF_XLEN-1:0] fetch_rdata;
  logic [`IF_XLEN-1:0] fetch_addr;
  logic                fetch_err;
  logic                id_we;

  if_pc_select u_pc_select (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mtvecx_i     (csr_mtvecx_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // pc_set_i doubles as the buffer flush
  if_fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_n_i (fetch_addr_n),
    .fetch_ready_i  (fetch_ready),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .fetch_err_o    (fetch_err),
    .busy_o         (if_busy_o)
  );

  if_id_register u_id_register (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .id_we_o             (id_we),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

  // the buffered address is the IF PC
  if_pc_check u_pc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .id_we_i             (id_we),
    .pc_set_i            (pc_set_i),
    .pc_if_i             (fetch_addr),
    .pc_id_i             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  assign pc_if_o = fetch_addr;

endmodule

// File: src/if_pc_check.sv
////////////////////////////////////////
// PC increment check
// flags an IF PC that is not ID PC plus one
// word while the stream is sequential
////////////////////////////////////////

`timescale 1ns/1ps

`include "if_config.svh"

module if_pc_check (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                id_we_i,
  input  logic                pc_set_i,
  input  logic [`IF_XLEN-1:0] pc_if_i,
  input  logic [`IF_XLEN-1:0] pc_id_i,
  output logic                pc_mismatch_alert_o
);

  localparam logic [`IF_XLEN-1:0] INSTR_INCR = `IF_INSTR_BYTES;

  logic                seq_d, seq_q;
  logic [`IF_XLEN-1:0] pc_expect;

  // sequential once a word reached ID, any jump, trap or return breaks it
  assign seq_d = (seq_q | id_we_i) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // expectation comes from the registered ID PC
  assign pc_expect = pc_id_i + INSTR_INCR;

  assign pc_mismatch_alert_o = seq_q & (pc_if_i != pc_expect);

endmodule

// File: src/if_id_register.sv
////////////////////////////////////////
// IF-ID pipeline register
// valid and new flags plus instruction,
// PC and bus error of the ID stage
////////////////////////////////////////

`timescale 1ns/1ps

`include "if_config.svh"

module if_id_register (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_valid_i,
  input  logic [`IF_XLEN-1:0] fetch_rdata_i,
  input  logic [`IF_XLEN-1:0] fetch_addr_i,
  input  logic                fetch_err_i,
  input  logic                id_in_ready_i,
  input  logic                pc_set_i,
  input  logic                instr_valid_clear_i,
  output logic                fetch_ready_o,
  output logic                id_we_o,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [`IF_XLEN-1:0] instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output logic [`IF_XLEN-1:0] pc_id_o
);

  logic id_we;
  logic valid_d, valid_q;
  logic new_q;

  // ID takes the buffered word whenever it is ready
  assign id_we         = fetch_valid_i & id_in_ready_i;
  assign fetch_ready_o = id_in_ready_i;

  // a redirect in the same cycle squashes the incoming word
  // otherwise valid holds until the controller clears it
  assign valid_d = (id_we & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= id_we;
    end
  end

  // ID registers freeze while ID stalls
  always_ff @(posedge clk_i) begin
    if (id_we) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      instr_fetch_err_o <= fetch_err_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

  assign id_we_o          = id_we;
  assign instr_valid_id_o = valid_q;
  // one cycle pulse per word entering ID
  assign instr_new_id_o   = new_q;

endmodule

// File: src/if_fetch_unit.sv
////////////////////////////////////////
// instruction fetch unit
// one bus request in flight, one-entry
// response buffer, flushed by pc_set_i
////////////////////////////////////////

`timescale 1ns/1ps

`include "if_config.svh"

module if_fetch_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                pc_set_i,
  input  logic [`IF_XLEN-1:0] fetch_addr_n_i,
  input  logic                fetch_ready_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [`IF_XLEN-1:0] instr_rdata_i,
  input  logic                instr_err_i,
  output logic                instr_req_o,
  output logic [`IF_XLEN-1:0] instr_addr_o,
  output logic                fetch_valid_o,
  output logic [`IF_XLEN-1:0] fetch_rdata_o,
  output logic [`IF_XLEN-1:0] fetch_addr_o,
  output logic                fetch_err_o,
  output logic                busy_o
);

  localparam logic [`IF_XLEN-1:0] INSTR_INCR = `IF_INSTR_BYTES;

  if_pkg::fetch_state_e state_q, state_d;

  logic [`IF_XLEN-1:0] aligned_addr;
  logic [`IF_XLEN-1:0] next_addr_q;
  logic [`IF_XLEN-1:0] req_addr_q;
  logic                discard_q, discard_d;
  logic                rsp_done;
  logic                new_req;
  logic                can_issue;
  logic                buf_valid_q;
  logic                buf_we;
  logic                buf_pop;
  logic [`IF_XLEN-1:0] buf_data_q;
  logic [`IF_XLEN-1:0] buf_addr_q;
  logic                buf_err_q;

  // word fetches only, low two bits dropped
  assign aligned_addr = {fetch_addr_n_i[`IF_XLEN-1:2], 2'b00};

  assign rsp_done = (state_q == if_pkg::FETCH_WAIT) & instr_rvalid_i;
  assign buf_pop  = buf_valid_q & fetch_ready_i;
  // keep the slot free for the response: issue only if it is empty next cycle
  assign can_issue = req_i & (~buf_valid_q | buf_pop | pc_set_i);
  // a stale or flushed response never lands in the buffer
  assign buf_we = rsp_done & ~discard_q & ~pc_set_i;

  ////////////////////////////////////////
  // bus FSM
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      if_pkg::FETCH_IDLE: begin
        if (can_issue) begin
          state_d = if_pkg::FETCH_REQ;
        end
      end
      if_pkg::FETCH_REQ: begin
        if (instr_gnt_i) begin
          state_d = if_pkg::FETCH_WAIT;
        end
      end
      if_pkg::FETCH_WAIT: begin
        // a dropped response leaves the buffer empty, refetch straight away
        if (instr_rvalid_i) begin
          state_d = (req_i & (discard_q | pc_set_i)) ? if_pkg::FETCH_REQ : if_pkg::FETCH_IDLE;
        end
      end
      default: state_d = if_pkg::FETCH_IDLE;
    endcase
  end

  assign new_req = (state_d == if_pkg::FETCH_REQ) & (state_q != if_pkg::FETCH_REQ);

  // redirect with a request outstanding, its response must be dropped
  always_comb begin
    discard_d = discard_q;
    if (pc_set_i && (state_q != if_pkg::FETCH_IDLE)) begin
      discard_d = 1'b1;
    end
    if (rsp_done) begin
      discard_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= if_pkg::FETCH_IDLE;
      discard_q   <= 1'b0;
      next_addr_q <= '0;
      req_addr_q  <= '0;
      buf_valid_q <= 1'b0;
      buf_addr_q  <= '0;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
      // next request address, advances only on a grant for the live stream
      if (pc_set_i) begin
        next_addr_q <= aligned_addr;
      end else if ((state_q == if_pkg::FETCH_REQ) && instr_gnt_i && !discard_q) begin
        next_addr_q <= next_addr_q + INSTR_INCR;
      end
      // bus address is held from request entry until the response
      if (new_req) begin
        req_addr_q <= pc_set_i ? aligned_addr : next_addr_q;
      end
      if (pc_set_i) begin
        buf_valid_q <= 1'b0;
      end else if (buf_we) begin
        buf_valid_q <= 1'b1;
      end else if (buf_pop) begin
        buf_valid_q <= 1'b0;
      end
      // IF PC, steps past a consumed word so it always names the next one
      if (pc_set_i) begin
        buf_addr_q <= aligned_addr;
      end else if (buf_we) begin
        buf_addr_q <= req_addr_q;
      end else if (buf_pop) begin
        buf_addr_q <= buf_addr_q + INSTR_INCR;
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (buf_we) begin
      buf_data_q <= instr_rdata_i;
      buf_err_q  <= instr_err_i;
    end
  end

  assign instr_req_o   = (state_q == if_pkg::FETCH_REQ);
  assign instr_addr_o  = req_addr_q;
  assign fetch_valid_o = buf_valid_q;
  assign fetch_rdata_o = buf_data_q;
  assign fetch_addr_o  = buf_addr_q;
  assign fetch_err_o   = buf_err_q;
  assign busy_o        = (state_q != if_pkg::FETCH_IDLE);

endmodule

// File: src/if_pc_select.sv
////////////////////////////////////////
// next fetch address selection
// combinational, feeds the fetch unit on
// every pc_set_i pulse
////////////////////////////////////////

`timescale 1ns/1ps

`include "if_config.svh"

module if_pc_select (
  input  logic                      pc_set_i,
  input  if_pkg::pc_sel_e           pc_mux_i,
  input  if_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  logic [5:0]                exc_cause_i,
  input  logic [`IF_XLEN-1:0]       boot_addr_i,
  input  logic [`IF_XLEN-1:0]       branch_target_i,
  input  logic [`IF_XLEN-1:0]       csr_mepc_i,
  input  logic [`IF_XLEN-1:0]       csr_depc_i,
  input  logic [`IF_XLEN-1:0]       csr_mtvec_i,
  input  logic [`IF_XLEN-1:0]       csr_mtvecx_i,
  output logic [`IF_XLEN-1:0]       fetch_addr_n_o,
  output logic                      csr_mtvec_init_o
);

  logic [`IF_XLEN-1:0] mtvec_base;
  logic [`IF_XLEN-1:0] mtvecx_base;
  logic [`IF_XLEN-1:0] boot_pc;
  logic [`IF_XLEN-1:0] irq_offset;
  logic [`IF_XLEN-1:0] exc_pc;

  // vector bases drop the low bits, they are mode and reserved fields
  assign mtvec_base  = {csr_mtvec_i[`IF_XLEN-1:`IF_VEC_BASE_LSB], {`IF_VEC_BASE_LSB{1'b0}}};
  assign mtvecx_base = {csr_mtvecx_i[`IF_XLEN-1:`IF_VEC_BASE_LSB], {`IF_VEC_BASE_LSB{1'b0}}};
  assign boot_pc     = {boot_addr_i[`IF_XLEN-1:`IF_VEC_BASE_LSB], {`IF_VEC_BASE_LSB{1'b0}}}
                       | `IF_BOOT_OFFSET;

  // interrupt id is in the low five cause bits, one word per entry
  // bit 5 only tells interrupt from exception, the select already says that
  assign irq_offset = {{(`IF_XLEN-7){1'b0}}, exc_cause_i[4:0], 2'b00};

  ////////////////////////////////////////
  // trap vector mux
  ////////////////////////////////////////
  always_comb begin
    case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      if_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      if_pkg::EXC_PC_IRQ_X:   exc_pc = mtvecx_base + irq_offset;
      if_pkg::EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:                exc_pc = mtvec_base;
    endcase
  end

  ////////////////////////////////////////
  // next fetch address mux
  ////////////////////////////////////////
  always_comb begin
    case (pc_mux_i)
      if_pkg::PC_BOOT: fetch_addr_n_o = boot_pc;
      if_pkg::PC_JUMP: fetch_addr_n_o = branch_target_i;
      // trap entry
      if_pkg::PC_EXC:  fetch_addr_n_o = exc_pc;
      // mret and dret
      if_pkg::PC_ERET: fetch_addr_n_o = csr_mepc_i;
      if_pkg::PC_DRET: fetch_addr_n_o = csr_depc_i;
      default:         fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file loads its mtvec reset value when we boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

// File: src/if_pkg.sv
////////////////////////////////////////
// enum types shared by the fetch stage
// reference with if_pkg:: scoped names
////////////////////////////////////////

package if_pkg;

  // next-PC source, driven by the controller with pc_set_i
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap vector source, only looked at for PC_EXC
  typedef enum logic [2:0] {
    EXC_PC_EXC     = 3'd0,
    EXC_PC_IRQ     = 3'd1,
    EXC_PC_IRQ_X   = 3'd2,
    EXC_PC_DBD     = 3'd3,
    EXC_PC_DBG_EXC = 3'd4
  } exc_pc_sel_e;

  // fetch unit bus FSM
  // idle, request held until grant, waiting for rvalid
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_REQ  = 2'd1,
    FETCH_WAIT = 2'd2
  } fetch_state_e;

endpackage

// File: include/if_config.svh
////////////////////////////////////////
// shared constants of the fetch stage
// include wherever widths, vector bases or
// debug entry points are needed
////////////////////////////////////////

`ifndef IF_CONFIG_SVH
`define IF_CONFIG_SVH

// datapath width, addresses and instructions
`define IF_XLEN 32

// low byte ORed onto the aligned boot base
`define IF_BOOT_OFFSET 32'h0000_0080

// mtvec, mtvecx and boot_addr keep bits from here up
`define IF_VEC_BASE_LSB 8

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR 32'h1A11_0808

// sequential step, only full words are fetched
`define IF_INSTR_BYTES 4

`endif
